// ==== sim.f ====
tlc_pkg.sv
matrix_pkg.sv
tlc_bit_timer.sv
led_refresh_fsm.sv
gs_frame_buffer.sv
tlc_shift_lane.sv
led_matrix_top.sv
led_matrix_asserts.sv
led_matrix_tb.sv

// ==== led_matrix_tb.sv ====
`timescale 1ns/100ps

module led_matrix_tb
	import tlc_pkg::*, matrix_pkg::*;
();

	localparam int FRAME_BITS    = NUM_CHAINED * LATCH_SIZE; // sclk rises per frame
	localparam int FRAME_TIMEOUT = 4000; // cycles per wait against about 3080 per frame
	localparam int BATCH_WRITES  = 40;   // pixel writes per random batch

	typedef logic [LATCH_SIZE-1:0] word_t;

	logic      TESTCLK;
	logic      reset;
	logic      pix_wr_strobe;
	pix_wr_t   pix_wr;
	led_pins_t led_pins;

	gs_word_t model_gs [NUM_LANES][NUM_CHAINED][GS_SLOTS]; // mirror of the pixel buffer

	word_t   cap_word  [NUM_LANES][NUM_CHAINED]; // frame being shifted with index 0 as first word
	word_t   done_word [NUM_LANES][NUM_CHAINED]; // last latched frame
	int      rise_cnt   = 0;
	int      done_rises = 0;
	int      frame_cnt  = 0; // lat pulses seen
	pix_wr_t prev_wr [$];    // addresses of the first batch

	led_matrix_top led_matrix_top_i (
		.TESTCLK       (TESTCLK),
		.reset         (reset),
		.pix_wr_strobe (pix_wr_strobe),
		.pix_wr        (pix_wr),
		.led_pins      (led_pins)
	);

	initial begin
		TESTCLK = 1'b0;
		forever #50 TESTCLK = ~TESTCLK; // 100 ns period
	end

	// serial capture at the falling edge where pins are stable mid cycle
	always @(negedge TESTCLK) begin : capture
		int pos;
		int bpos;
		if (reset) begin
			rise_cnt = 0;
		end else begin
			if (led_pins.sclk) begin
				pos  = rise_cnt / LATCH_SIZE;
				bpos = LATCH_SIZE - 1 - (rise_cnt % LATCH_SIZE); // msb first
				if (pos < NUM_CHAINED) begin
					for (int l = 0; l < NUM_LANES; l++) begin
						cap_word[l][pos][bpos] = led_pins.sdo[l];
					end
				end
				rise_cnt = rise_cnt + 1;
			end
			if (led_pins.lat) begin
				for (int l = 0; l < NUM_LANES; l++) begin
					for (int p = 0; p < NUM_CHAINED; p++) begin
						done_word[l][p] = cap_word[l][p];
					end
				end
				done_rises = rise_cnt;
				rise_cnt   = 0;     // next frame starts right away
				frame_cnt  = frame_cnt + 1;
			end
		end
	end

	always @(negedge TESTCLK) begin
		if (led_matrix_top_i.led_matrix_asserts_i.fail_count != 0) begin
			$display("protocol assertion failed at %0t ns", $time);
			$display("Some tests failed");
			$fatal(1, "protocol assertion failed");
		end
	end

	task automatic check_value(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
			$display("Some tests failed");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	// wait for the next lat pulse
	task automatic wait_frame_end();
		int start;
		int cycles;
		start  = frame_cnt;
		cycles = 0;
		while (frame_cnt == start) begin
			if (cycles == FRAME_TIMEOUT) begin
				$display("timeout at %0t ns: no lat pulse within %0d cycles",
					$time, FRAME_TIMEOUT);
				$display("Some tests failed");
				$fatal(1, "lat pulse never came");
			end
			@(posedge TESTCLK);
			cycles++;
		end
	endtask

	// control latch from the fixed settings
	function automatic word_t build_ctrl_word();
		word_t w;
		w = '0;
		w[LATCH_SIZE-1] = 1'b1; // control select
		for (int c = 0; c < NUM_CHANNELS; c++) begin
			for (int k = 0; k < NUM_COLORS; k++) begin
				w[DC_BASE + DC_BITS*(NUM_COLORS*c + k) +: DC_BITS] = 7'd127;
			end
		end
		for (int k = 0; k < NUM_COLORS; k++) begin
			w[MC_BASE + MC_BITS*k +: MC_BITS] = 3'd0; // lowest current
			w[BC_BASE + BC_BITS*k +: BC_BITS] = 7'd127;
		end
		w[FC_BASE + 0] = 1'b1; // display repeat
		w[FC_BASE + 1] = 1'b0; // timing reset
		w[FC_BASE + 2] = 1'b0; // auto refresh
		w[FC_BASE + 3] = 1'b1; // es-pwm
		w[FC_BASE + 4] = 1'b1; // lsd voltage
		return w;
	endfunction

	// grayscale latch of one driver from the model
	function automatic word_t build_gs_word(input int lane, input int chain);
		word_t w;
		w = '0; // bit 768 stays 0
		for (int s = 0; s < GS_SLOTS; s++) begin
			w[GS_BITS*s +: GS_BITS] = model_gs[lane][chain][s];
		end
		return w;
	endfunction

	task automatic check_frame(input bit ctrl, input string tag);
		word_t exp;
		check_value({tag, " sclk rises"}, word_t'(done_rises), word_t'(FRAME_BITS));
		for (int l = 0; l < NUM_LANES; l++) begin
			for (int p = 0; p < NUM_CHAINED; p++) begin
				// farthest driver goes out first
				exp = ctrl ? build_ctrl_word() : build_gs_word(l, NUM_CHAINED - 1 - p);
				check_value($sformatf("%s lane %0d sdo word %0d", tag, l, p),
					done_word[l][p], exp);
			end
		end
	endtask

	// one write per cycle where reuse picks earlier addresses half the time
	task automatic write_batch(input bit reuse);
		pix_wr_t wr;
		for (int i = 0; i < BATCH_WRITES; i++) begin
			if (reuse && prev_wr.size() > 0 && ($urandom % 2 == 1)) begin
				wr = prev_wr[$urandom % prev_wr.size()];
			end else begin
				wr.lane  = lane_idx_t'($urandom % NUM_LANES);
				wr.chain = chain_idx_t'($urandom % NUM_CHAINED);
				wr.slot  = slot_idx_t'($urandom % GS_SLOTS);
			end
			wr.value = gs_word_t'($urandom);
			@(posedge TESTCLK);
			#10;
			pix_wr        = wr;
			pix_wr_strobe = 1'b1;
			model_gs[wr.lane][wr.chain][wr.slot] = wr.value;
			if (!reuse) begin
				prev_wr.push_back(wr);
			end
		end
		@(posedge TESTCLK);
		#10;
		pix_wr_strobe = 1'b0;
	endtask

	initial begin
		void'($urandom(25));
		reset         = 1'b1;
		pix_wr_strobe = 1'b0;
		pix_wr        = '0;
		for (int l = 0; l < NUM_LANES; l++) begin
			for (int c = 0; c < NUM_CHAINED; c++) begin
				for (int s = 0; s < GS_SLOTS; s++) begin
					model_gs[l][c][s] = '0; // buffer clears on reset
				end
			end
		end

		repeat (10) @(posedge TESTCLK);
		#10;
		check_value("led_pins in reset", word_t'(led_pins), '0);
		reset = 1'b0;
		@(negedge TESTCLK);
		check_value("led_pins before first load", word_t'(led_pins), '0);

		wait_frame_end();
		check_frame(1'b1, "control frame");
		wait_frame_end();
		check_frame(1'b0, "empty frame 1");
		wait_frame_end();
		check_frame(1'b0, "empty frame 2");

		write_batch(1'b0);
		wait_frame_end(); // may hold a part of the writes
		wait_frame_end();
		check_frame(1'b0, "batch 1 frame");

		write_batch(1'b1);
		wait_frame_end();
		wait_frame_end();
		check_frame(1'b0, "batch 2 frame");

		if (led_matrix_top_i.led_matrix_asserts_i.fail_count == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			$display("protocol assertions failed %0d times",
				led_matrix_top_i.led_matrix_asserts_i.fail_count);
			$display("Some tests failed");
			$fatal(1, "protocol assertions failed");
		end
	end

endmodule

// ==== led_matrix_asserts.sv ====
`timescale 1ns/100ps

module led_matrix_asserts
	import matrix_pkg::*;
(
	input logic      TESTCLK,
	input logic      reset,
	input led_pins_t led_pins
);

	int fail_count = 0; // failures so far, read at the end of the run

	// one high cycle per bit period
	sclk_single: assert property (@(posedge TESTCLK) disable iff (reset)
		led_pins.sclk |=> !led_pins.sclk)
		else begin
			fail_count++;
			$error("sclk high for two cycles in a row");
		end

	// latch pulse is a single cycle
	lat_single: assert property (@(posedge TESTCLK) disable iff (reset)
		led_pins.lat |=> !led_pins.lat)
		else begin
			fail_count++;
			$error("lat high for two cycles in a row");
		end

	lat_sclk_low: assert property (@(posedge TESTCLK) disable iff (reset)
		!(led_pins.lat && led_pins.sclk))
		else begin
			fail_count++;
			$error("lat high while sclk high");
		end

	// no x on the driver pins once out of reset
	pins_known: assert property (@(posedge TESTCLK) disable iff (reset)
		!$isunknown(led_pins))
		else begin
			fail_count++;
			$error("unknown value on led pins");
		end

endmodule

bind led_matrix_top led_matrix_asserts led_matrix_asserts_i (
	.TESTCLK  (TESTCLK),
	.reset    (reset),
	.led_pins (led_pins)
);

// ==== led_matrix_top.sv ====
`timescale 1ns/100ps

module led_matrix_top
	import tlc_pkg::*, matrix_pkg::*;
(
	input  logic      TESTCLK,
	input  logic      reset,
	input  logic      pix_wr_strobe, // one write per high cycle
	input  pix_wr_t   pix_wr,
	output led_pins_t led_pins
);

	logic                      load_word;
	logic                      sclk_rise;
	logic                      latch_pulse;
	logic                      ctrl_phase;
	logic                      bit_last;
	logic                      chain_last;
	chain_idx_t                chain_idx;
	logic                      sclk;
	logic                      lat;
	gs_latch_t [NUM_LANES-1:0] lane_gs;
	logic [NUM_LANES-1:0]      sdo_bus;

	tlc_bit_timer tlc_bit_timer_i (
		.TESTCLK     (TESTCLK),
		.reset       (reset),
		.load_word   (load_word),
		.sclk_rise   (sclk_rise),
		.latch_pulse (latch_pulse),
		.bit_last    (bit_last),
		.chain_last  (chain_last),
		.chain_idx   (chain_idx)
	);

	led_refresh_fsm led_refresh_fsm_i (
		.TESTCLK     (TESTCLK),
		.reset       (reset),
		.bit_last    (bit_last),
		.chain_last  (chain_last),
		.load_word   (load_word),
		.sclk_rise   (sclk_rise),
		.latch_pulse (latch_pulse),
		.ctrl_phase  (ctrl_phase),
		.sclk        (sclk),
		.lat         (lat)
	);

	gs_frame_buffer gs_frame_buffer_i (
		.TESTCLK       (TESTCLK),
		.reset         (reset),
		.pix_wr_strobe (pix_wr_strobe),
		.pix_wr        (pix_wr),
		.chain_idx     (chain_idx),
		.lane_gs       (lane_gs)
	);

	// one shifter per sdo line, all in lockstep
	for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
		tlc_shift_lane tlc_shift_lane_i (
			.TESTCLK    (TESTCLK),
			.reset      (reset),
			.ctrl_phase (ctrl_phase),
			.gs         (lane_gs[l]),
			.load_word  (load_word),
			.sclk_rise  (sclk_rise),
			.sdo        (sdo_bus[l])
		);
	end

	assign led_pins = '{sclk: sclk, lat: lat, sdo: sdo_bus};

endmodule

// ==== tlc_shift_lane.sv ====
`timescale 1ns/100ps

module tlc_shift_lane
	import tlc_pkg::*;
(
	input  logic      TESTCLK,
	input  logic      reset,
	input  logic      ctrl_phase, // pick control or grayscale word
	input  gs_latch_t gs,         // this lane's driver, from buffer
	input  logic      load_word,
	input  logic      sclk_rise,
	output logic      sdo
);

	logic [LATCH_SIZE-1:0] ctrl_word;
	logic [LATCH_SIZE-1:0] gs_word;
	logic [LATCH_SIZE-1:0] shreg; // msb is on the wire

	// control latch built from the fixed settings
	always_comb begin
		ctrl_word = '0; // unused bits stay 0
		ctrl_word[LATCH_SIZE-1] = 1'b1; // control latch select
		for (int c = 0; c < NUM_CHANNELS; c++) begin
			for (int k = 0; k < NUM_COLORS; k++) begin
				ctrl_word[DC_BASE + DC_BITS*(NUM_COLORS*c + k) +: DC_BITS] =
					CTRL_SETTINGS.dc[k];
			end
		end
		for (int k = 0; k < NUM_COLORS; k++) begin
			ctrl_word[MC_BASE + MC_BITS*k +: MC_BITS] = CTRL_SETTINGS.mc[k];
			ctrl_word[BC_BASE + BC_BITS*k +: BC_BITS] = CTRL_SETTINGS.bc[k];
		end
		ctrl_word[FC_BASE +: FC_BITS] = CTRL_SETTINGS.fc; // dsprpt at 366
	end

	// grayscale latch, select bit 0 on top of the 48 slots
	assign gs_word = {1'b0, gs};

	always_ff @(posedge TESTCLK) begin
		if (reset) begin
			shreg <= '0; // keeps sdo low until first load
		end else if (load_word) begin
			shreg <= ctrl_phase ? ctrl_word : gs_word;
		end else if (sclk_rise) begin
			shreg <= {shreg[LATCH_SIZE-2:0], 1'b0}; // next bit as sclk falls
		end
	end

	assign sdo = shreg[LATCH_SIZE-1];

endmodule

// ==== gs_frame_buffer.sv ====
`timescale 1ns/100ps

module gs_frame_buffer
	import tlc_pkg::*, matrix_pkg::*;
(
	input  logic                        TESTCLK,
	input  logic                        reset,
	input  logic                        pix_wr_strobe,
	input  pix_wr_t                     pix_wr,
	input  chain_idx_t                  chain_idx, // driver being loaded
	output gs_latch_t [NUM_LANES-1:0]   lane_gs    // one latch per lane
);

	// grayscale store, lane x driver x slot
	gs_latch_t [NUM_CHAINED-1:0] mem [NUM_LANES];

	always_ff @(posedge TESTCLK) begin
		if (reset) begin
			for (int l = 0; l < NUM_LANES; l++) begin
				mem[l] <= '0; // dark after reset
			end
		end else if (pix_wr_strobe && (pix_wr.slot < GS_SLOTS)) begin
			// slots 48..63 do not exist, dropped
			mem[pix_wr.lane][pix_wr.chain][pix_wr.slot] <= pix_wr.value;
		end
	end

	// combinational read, lanes only sample it on their load cycle
	always_comb begin
		for (int l = 0; l < NUM_LANES; l++) begin
			lane_gs[l] = mem[l][chain_idx];
		end
	end

endmodule

// ==== led_refresh_fsm.sv ====
`timescale 1ns/100ps

module led_refresh_fsm (
	input  logic TESTCLK,
	input  logic reset,
	input  logic bit_last,    // from timer
	input  logic chain_last,  // from timer
	output logic load_word,   // lanes load their word
	output logic sclk_rise,   // cycle with sclk high, lanes shift after it
	output logic latch_pulse,
	output logic ctrl_phase,  // 1 until the control frame is latched
	output logic sclk,
	output logic lat
);

	typedef enum logic [2:0] {
		LOAD,
		SHIFT_LOW,  // sdo settles, sclk low
		SHIFT_HIGH, // driver samples sdo
		NEXT,       // gap before next driver's word
		LATCH
	} state_t;

	state_t state_q;
	state_t state_d;
	logic   ctrl_q;

	always_ff @(posedge TESTCLK) begin
		if (reset) begin
			state_q <= LOAD;
			ctrl_q  <= 1'b1; // control latch goes first
		end else begin
			state_q <= state_d;
			if (latch_pulse) begin
				ctrl_q <= 1'b0; // grayscale from here on
			end
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			LOAD:       state_d = SHIFT_LOW;
			SHIFT_LOW:  state_d = SHIFT_HIGH;
			SHIFT_HIGH: begin
				// chain index still points at the current word here
				if (!bit_last) begin
					state_d = SHIFT_LOW;
				end else if (chain_last) begin
					state_d = LATCH;
				end else begin
					state_d = NEXT;
				end
			end
			NEXT:       state_d = LOAD;
			LATCH:      state_d = LOAD; // straight into the next frame
			default:    state_d = LOAD;
		endcase
	end

	// strobes and pins decoded from state
	assign load_word   = (state_q == LOAD);
	assign sclk_rise   = (state_q == SHIFT_HIGH);
	assign latch_pulse = (state_q == LATCH);
	assign ctrl_phase  = ctrl_q;
	assign sclk        = (state_q == SHIFT_HIGH); // low in every other state
	assign lat         = (state_q == LATCH);

endmodule

// ==== tlc_bit_timer.sv ====
`timescale 1ns/100ps

module tlc_bit_timer
	import tlc_pkg::*, matrix_pkg::*;
(
	input  logic       TESTCLK,
	input  logic       reset,
	input  logic       load_word,   // start of a new latch word
	input  logic       sclk_rise,   // one bit period done
	input  logic       latch_pulse, // frame done
	output logic       bit_last,
	output logic       chain_last,
	output chain_idx_t chain_idx
);

	logic [BIT_CNT_W-1:0] bit_cnt; // bits still to go in this word

	// last bit while its sclk high phase is on
	assign bit_last   = (bit_cnt == BIT_CNT_W'(1));
	// nearest driver is the last word of a frame
	assign chain_last = (chain_idx == '0);

	always_ff @(posedge TESTCLK) begin
		if (reset) begin
			bit_cnt <= BIT_CNT_W'(LATCH_SIZE);
		end else if (load_word || latch_pulse) begin
			bit_cnt <= BIT_CNT_W'(LATCH_SIZE); // reload per word
		end else if (sclk_rise) begin
			bit_cnt <= bit_cnt - 1'b1;
		end
	end

	// frames start at the far end of the chain
	always_ff @(posedge TESTCLK) begin
		if (reset) begin
			chain_idx <= chain_idx_t'(NUM_CHAINED - 1);
		end else if (latch_pulse) begin
			chain_idx <= chain_idx_t'(NUM_CHAINED - 1);
		end else if (sclk_rise && bit_last && !chain_last) begin
			chain_idx <= chain_idx - 1'b1; // word done, move one driver closer
		end
	end

endmodule

// ==== matrix_pkg.sv ====
package matrix_pkg;

	import tlc_pkg::*; // grayscale word and slot count

	// matrix geometry
	localparam int NUM_LANES   = 4; // parallel sdo lines
	localparam int NUM_CHAINED = 2; // drivers per lane, daisy chained

	typedef logic [$clog2(NUM_LANES)-1:0] lane_idx_t;
	typedef logic [0:0]                   chain_idx_t; // 1 = farthest driver
	typedef logic [$clog2(GS_SLOTS)-1:0]  slot_idx_t;

	// one pixel write, 25 bits
	typedef struct packed {
		lane_idx_t  lane;
		chain_idx_t chain;
		slot_idx_t  slot;  // 3*channel + color
		gs_word_t   value;
	} pix_wr_t;

	// pins towards the drivers
	typedef struct packed {
		logic                 sclk;
		logic                 lat;
		logic [NUM_LANES-1:0] sdo; // one bit per lane
	} led_pins_t;

endpackage

// ==== tlc_pkg.sv ====
package tlc_pkg;

	// TLC5955 latch format
	localparam int LATCH_SIZE   = 769; // 768 data bits plus latch select
	localparam int NUM_CHANNELS = 16;  // led channels per driver
	localparam int NUM_COLORS   = 3;   // red, green, blue
	localparam int GS_BITS      = 16;  // grayscale width
	localparam int GS_SLOTS     = NUM_CHANNELS * NUM_COLORS; // 48 grayscale values per driver

	// control latch field widths
	localparam int DC_BITS = 7; // dot correction
	localparam int MC_BITS = 3; // max current
	localparam int BC_BITS = 7; // global brightness
	localparam int FC_BITS = 5; // function control bits

	// control latch field offsets
	localparam int DC_BASE = 0;
	localparam int MC_BASE = 336;
	localparam int BC_BASE = 345;
	localparam int FC_BASE = 366;

	// bit counter must hold LATCH_SIZE itself
	localparam int BIT_CNT_W = $clog2(LATCH_SIZE + 1);

	typedef logic [GS_BITS-1:0] gs_word_t;

	// slot s = 3c+k sits at bits 16s +: 16
	typedef gs_word_t [GS_SLOTS-1:0] gs_latch_t;

	// function bits, lsb lands on FC_BASE
	typedef struct packed {
		logic lsdvlt; // lsd detection voltage select
		logic espwm;  // es-pwm enable
		logic rfresh; // auto data refresh
		logic tmgrst; // display timing reset
		logic dsprpt; // auto display repeat
	} tlc_fc_t;

	// per color fields, index 0 is red
	typedef struct packed {
		logic [NUM_COLORS-1:0][DC_BITS-1:0] dc; // same dc for every channel of a color
		logic [NUM_COLORS-1:0][MC_BITS-1:0] mc;
		logic [NUM_COLORS-1:0][BC_BITS-1:0] bc;
		tlc_fc_t                            fc;
	} tlc_ctrl_t;

	// fixed settings loaded once after reset
	localparam tlc_ctrl_t CTRL_SETTINGS = '{
		dc: {NUM_COLORS{7'd127}}, // full dot correction
		mc: '0,                   // lowest max current
		bc: {NUM_COLORS{7'd127}}, // full brightness
		fc: '{
			lsdvlt: 1'b1,
			espwm:  1'b1,
			rfresh: 1'b0,
			tmgrst: 1'b0,
			dsprpt: 1'b1
		}
	};

endpackage
